/* hdl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    localparam int WORD_WIDTH      = 32;
    localparam int WORD_BYTES      = WORD_WIDTH / 8;
    localparam int LINE_WORDS      = 4;
    localparam int LINE_BYTES      = LINE_WORDS * WORD_BYTES;
    localparam int WORD_ADDR_WIDTH = 16;
    localparam int LINE_ADDR_WIDTH = WORD_ADDR_WIDTH - $clog2(LINE_WORDS);
    localparam int CORE_TAG_WIDTH  = 8;

    typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } req_op_e;

    typedef struct packed {
        req_op_e                    op;
        logic [WORD_BYTES-1:0]      byteen;
        logic [WORD_ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0]      data;
        logic [CORE_TAG_WIDTH-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0]     data;
        logic [CORE_TAG_WIDTH-1:0] tag;
    } core_rsp_t;

    // Line granular DRAM traffic
    typedef struct packed {
        req_op_e                    op;
        logic [LINE_ADDR_WIDTH-1:0] addr;
        line_t                      data;
        logic [LINE_BYTES-1:0]      byteen;
    } dram_req_t;

    typedef struct packed {
        logic [LINE_ADDR_WIDTH-1:0] addr;
        line_t                      data;
    } dram_rsp_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL_REQ,
        S_FILL_WAIT,
        S_WRITE_REQ,
        S_RSP
    } bank_state_e;

endpackage

`default_nettype wire

/* hdl/cache_bank_sel.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank_sel #(
    parameter int NUM_BANKS = 4
) (
    input  wire logic                 core_req_valid,
    input  wire cache_pkg::core_req_t core_req,
    input  wire logic [NUM_BANKS-1:0] bank_ready,
    input  wire logic                 dram_rsp_valid,
    input  wire cache_pkg::dram_rsp_t dram_rsp,
    output logic [NUM_BANKS-1:0]      bank_req_valid,
    output logic                      core_req_ready,
    output logic [NUM_BANKS-1:0]      bank_fill_valid
);

    localparam int OFFSET_BITS = $clog2(cache_pkg::LINE_WORDS);
    localparam int BANK_BITS   = $clog2(NUM_BANKS);

    logic [BANK_BITS-1:0] req_bank;
    logic [BANK_BITS-1:0] fill_bank;

    // Bank bits sit just above the word offset
    assign req_bank  = core_req.addr[OFFSET_BITS +: BANK_BITS];
    assign fill_bank = dram_rsp.addr[BANK_BITS-1:0];

    always_comb begin
        bank_req_valid = '0;
        bank_req_valid[req_bank] = core_req_valid;
    end

    always_comb begin
        bank_fill_valid = '0;
        bank_fill_valid[fill_bank] = dram_rsp_valid;
    end

    assign core_req_ready = bank_ready[req_bank];

endmodule

`default_nettype wire

/* hdl/cache_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_bank #(
    parameter int NUM_BANKS      = 4,
    parameter int LINES_PER_BANK = 32
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 req_valid,
    input  wire cache_pkg::core_req_t req,
    output logic                      req_ready,
    input  wire logic                 fill_valid,
    input  wire cache_pkg::dram_rsp_t fill,
    output logic                      dram_valid,
    output cache_pkg::dram_req_t      dram_req,
    input  wire logic                 dram_ready,
    output logic                      rsp_valid,
    output cache_pkg::core_rsp_t      rsp,
    input  wire logic                 rsp_ready
);

    localparam int OFFSET_BITS = $clog2(cache_pkg::LINE_WORDS);
    localparam int BANK_BITS   = $clog2(NUM_BANKS);
    localparam int INDEX_BITS  = $clog2(LINES_PER_BANK);
    localparam int TAG_BITS    = cache_pkg::LINE_ADDR_WIDTH - BANK_BITS - INDEX_BITS;

    cache_pkg::bank_state_e state_q;
    cache_pkg::core_req_t   req_q;
    cache_pkg::core_rsp_t   rsp_q;
    logic                   lookup_rd_q;
    logic                   lookup_done;

    logic [LINES_PER_BANK-1:0] valid_q;
    logic [TAG_BITS-1:0]       tag_mem [LINES_PER_BANK];
    cache_pkg::line_t          data_mem [LINES_PER_BANK];

    logic                rd_valid_q;
    logic [TAG_BITS-1:0] rd_tag_q;
    cache_pkg::line_t    rd_line_q;

    logic [cache_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
    logic [INDEX_BITS-1:0]                 req_idx;
    logic [TAG_BITS-1:0]                   req_tag;
    logic [OFFSET_BITS-1:0]                req_word;
    logic [INDEX_BITS-1:0]                 fill_idx;
    logic [TAG_BITS-1:0]                   fill_tag;
    logic                                  hit;
    logic [cache_pkg::WORD_WIDTH-1:0]      merged_word;
    cache_pkg::line_t                      merged_line;
    cache_pkg::line_t                      wt_line;
    logic [cache_pkg::LINE_BYTES-1:0]      wt_byteen;

    assign line_addr = req_q.addr[cache_pkg::WORD_ADDR_WIDTH-1:OFFSET_BITS];
    assign req_idx   = line_addr[BANK_BITS +: INDEX_BITS];
    assign req_tag   = line_addr[cache_pkg::LINE_ADDR_WIDTH-1 -: TAG_BITS];
    assign req_word  = req_q.addr[OFFSET_BITS-1:0];
    assign fill_idx  = fill.addr[BANK_BITS +: INDEX_BITS];
    assign fill_tag  = fill.addr[cache_pkg::LINE_ADDR_WIDTH-1 -: TAG_BITS];

    // Second lookup cycle sees the registered storage read
    assign lookup_done = (state_q == cache_pkg::S_LOOKUP) && lookup_rd_q;
    assign hit         = rd_valid_q && (rd_tag_q == req_tag);

    always_comb begin
        merged_word = rd_line_q[req_word];
        for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
            if (req_q.byteen[b]) begin
                merged_word[8*b +: 8] = req_q.data[8*b +: 8];
            end
        end
        merged_line = rd_line_q;
        merged_line[req_word] = merged_word;
    end

    // Write-through line carries only the written word
    always_comb begin
        wt_line = '0;
        wt_line[req_word] = req_q.data;
        wt_byteen = '0;
        wt_byteen[req_word*cache_pkg::WORD_BYTES +: cache_pkg::WORD_BYTES] = req_q.byteen;
    end

    always_ff @(posedge clk) begin
        rd_valid_q <= valid_q[req_idx];
        rd_tag_q   <= tag_mem[req_idx];
        rd_line_q  <= data_mem[req_idx];
    end

    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::S_FILL_WAIT && fill_valid) begin
            tag_mem[fill_idx]  <= fill_tag;
            data_mem[fill_idx] <= fill.data;
        end else if (lookup_done && hit && req_q.op == cache_pkg::OP_WRITE) begin
            data_mem[req_idx] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= cache_pkg::S_IDLE;
            lookup_rd_q <= 1'b0;
            valid_q     <= '0;
        end else begin
            case (state_q)
                cache_pkg::S_IDLE: begin
                    if (req_valid) begin
                        state_q <= cache_pkg::S_LOOKUP;
                    end
                end
                cache_pkg::S_LOOKUP: begin
                    lookup_rd_q <= !lookup_rd_q;
                    if (lookup_rd_q) begin
                        if (req_q.op == cache_pkg::OP_WRITE) begin
                            state_q <= cache_pkg::S_WRITE_REQ;
                        end else if (hit) begin
                            state_q <= cache_pkg::S_RSP;
                        end else begin
                            state_q <= cache_pkg::S_FILL_REQ;
                        end
                    end
                end
                cache_pkg::S_FILL_REQ: begin
                    if (dram_ready) begin
                        state_q <= cache_pkg::S_FILL_WAIT;
                    end
                end
                cache_pkg::S_FILL_WAIT: begin
                    if (fill_valid) begin
                        valid_q[fill_idx] <= 1'b1;
                        state_q           <= cache_pkg::S_RSP;
                    end
                end
                cache_pkg::S_WRITE_REQ: begin
                    if (dram_ready) begin
                        state_q <= cache_pkg::S_IDLE;
                    end
                end
                cache_pkg::S_RSP: begin
                    if (rsp_ready) begin
                        state_q <= cache_pkg::S_IDLE;
                    end
                end
                default: state_q <= cache_pkg::S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::S_IDLE && req_valid) begin
            req_q <= req;
        end
        if (lookup_done && hit) begin
            rsp_q.data <= rd_line_q[req_word];
            rsp_q.tag  <= req_q.tag;
        end else if (state_q == cache_pkg::S_FILL_WAIT && fill_valid) begin
            rsp_q.data <= fill.data[req_word];
            rsp_q.tag  <= req_q.tag;
        end
    end

    assign req_ready  = (state_q == cache_pkg::S_IDLE);
    assign rsp_valid  = (state_q == cache_pkg::S_RSP);
    assign rsp        = rsp_q;
    assign dram_valid = (state_q == cache_pkg::S_FILL_REQ) ||
                        (state_q == cache_pkg::S_WRITE_REQ);

    always_comb begin
        dram_req.addr = line_addr;
        if (state_q == cache_pkg::S_WRITE_REQ) begin
            dram_req.op     = cache_pkg::OP_WRITE;
            dram_req.data   = wt_line;
            dram_req.byteen = wt_byteen;
        end else begin
            dram_req.op     = cache_pkg::OP_READ;
            dram_req.data   = '0;
            dram_req.byteen = '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_dram_req_arb.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_dram_req_arb #(
    parameter int NUM_BANKS = 4
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic [NUM_BANKS-1:0]                 bank_valid,
    input  wire cache_pkg::dram_req_t [NUM_BANKS-1:0] bank_req,
    output logic [NUM_BANKS-1:0]                      bank_ready,
    output logic                                      dram_req_valid,
    output cache_pkg::dram_req_t                      dram_req,
    input  wire logic                                 dram_req_ready
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);

    logic [BANK_BITS-1:0] rr_q;
    logic [BANK_BITS-1:0] grant_idx;
    logic                 grant_valid;
    logic                 load;
    logic                 out_valid_q;
    cache_pkg::dram_req_t out_q;

    // Search starts at the pointer and wraps
    always_comb begin
        logic [BANK_BITS-1:0] cand;
        grant_valid = 1'b0;
        grant_idx   = rr_q;
        for (int i = 0; i < NUM_BANKS; i++) begin
            cand = rr_q + BANK_BITS'(i);
            if (!grant_valid && bank_valid[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    // Single entry, refilled when empty or draining
    assign load = !out_valid_q || dram_req_ready;

    always_comb begin
        bank_ready = '0;
        bank_ready[grant_idx] = load && grant_valid;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
            rr_q        <= '0;
        end else if (load) begin
            out_valid_q <= grant_valid;
            if (grant_valid) begin
                rr_q <= grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && grant_valid) begin
            out_q <= bank_req[grant_idx];
        end
    end

    assign dram_req_valid = out_valid_q;
    assign dram_req       = out_q;

endmodule

`default_nettype wire

/* hdl/cache_core_rsp_merge.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_core_rsp_merge #(
    parameter int NUM_BANKS = 4
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic [NUM_BANKS-1:0]                 bank_valid,
    input  wire cache_pkg::core_rsp_t [NUM_BANKS-1:0] bank_rsp,
    output logic [NUM_BANKS-1:0]                      bank_ready,
    output logic                                      core_rsp_valid,
    output cache_pkg::core_rsp_t                      core_rsp,
    input  wire logic                                 core_rsp_ready
);

    localparam int BANK_BITS = $clog2(NUM_BANKS);

    logic [BANK_BITS-1:0] rr_q;
    logic [BANK_BITS-1:0] sel_idx;
    logic                 sel_valid;
    logic                 take;
    logic                 rsp_valid_q;
    cache_pkg::core_rsp_t rsp_q;

    always_comb begin
        logic [BANK_BITS-1:0] cand;
        sel_valid = 1'b0;
        sel_idx   = rr_q;
        for (int i = 0; i < NUM_BANKS; i++) begin
            cand = rr_q + BANK_BITS'(i);
            if (!sel_valid && bank_valid[cand]) begin
                sel_valid = 1'b1;
                sel_idx   = cand;
            end
        end
    end

    assign take = !rsp_valid_q || core_rsp_ready;

    always_comb begin
        bank_ready = '0;
        bank_ready[sel_idx] = take && sel_valid;
    end

    // Pointer moves past the bank just served
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid_q <= 1'b0;
            rr_q        <= '0;
        end else if (take) begin
            rsp_valid_q <= sel_valid;
            if (sel_valid) begin
                rr_q <= sel_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && sel_valid) begin
            rsp_q <= bank_rsp[sel_idx];
        end
    end

    assign core_rsp_valid = rsp_valid_q;
    assign core_rsp       = rsp_q;

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
    parameter int NUM_BANKS      = 4,
    parameter int LINES_PER_BANK = 32
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,

    input  wire logic                 core_req_valid,
    input  wire cache_pkg::core_req_t core_req,
    output logic                      core_req_ready,

    output logic                      core_rsp_valid,
    output cache_pkg::core_rsp_t      core_rsp,
    input  wire logic                 core_rsp_ready,

    output logic                      dram_req_valid,
    output cache_pkg::dram_req_t      dram_req,
    input  wire logic                 dram_req_ready,

    input  wire logic                 dram_rsp_valid,
    input  wire cache_pkg::dram_rsp_t dram_rsp
);

    wire [NUM_BANKS-1:0]                      bank_req_valid;
    wire [NUM_BANKS-1:0]                      bank_req_ready;
    wire [NUM_BANKS-1:0]                      bank_fill_valid;
    wire [NUM_BANKS-1:0]                      bank_dram_valid;
    wire [NUM_BANKS-1:0]                      bank_dram_ready;
    wire cache_pkg::dram_req_t [NUM_BANKS-1:0] bank_dram_req;
    wire [NUM_BANKS-1:0]                      bank_rsp_valid;
    wire [NUM_BANKS-1:0]                      bank_rsp_ready;
    wire cache_pkg::core_rsp_t [NUM_BANKS-1:0] bank_rsp;

    cache_bank_sel #(
        .NUM_BANKS (NUM_BANKS)
    ) u_bank_sel (
        .core_req_valid  (core_req_valid),
        .core_req        (core_req),
        .bank_ready      (bank_req_ready),
        .dram_rsp_valid  (dram_rsp_valid),
        .dram_rsp        (dram_rsp),
        .bank_req_valid  (bank_req_valid),
        .core_req_ready  (core_req_ready),
        .bank_fill_valid (bank_fill_valid)
    );

    // Request and fill payloads go to every bank
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        cache_bank #(
            .NUM_BANKS      (NUM_BANKS),
            .LINES_PER_BANK (LINES_PER_BANK)
        ) u_bank (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_valid  (bank_req_valid[i]),
            .req        (core_req),
            .req_ready  (bank_req_ready[i]),
            .fill_valid (bank_fill_valid[i]),
            .fill       (dram_rsp),
            .dram_valid (bank_dram_valid[i]),
            .dram_req   (bank_dram_req[i]),
            .dram_ready (bank_dram_ready[i]),
            .rsp_valid  (bank_rsp_valid[i]),
            .rsp        (bank_rsp[i]),
            .rsp_ready  (bank_rsp_ready[i])
        );
    end

    cache_dram_req_arb #(
        .NUM_BANKS (NUM_BANKS)
    ) u_dram_req_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .bank_valid     (bank_dram_valid),
        .bank_req       (bank_dram_req),
        .bank_ready     (bank_dram_ready),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready)
    );

    cache_core_rsp_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) u_core_rsp_merge (
        .clk            (clk),
        .rst_n          (rst_n),
        .bank_valid     (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_ready     (bank_rsp_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready)
    );

endmodule

`default_nettype wire

/* testbench/dram_model.sv */
`timescale 1ns/1ns
`default_nettype none

module dram_model (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 req_valid,
    input  wire cache_pkg::dram_req_t req,
    output logic                      req_ready,
    output logic                      rsp_valid,
    output cache_pkg::dram_rsp_t      rsp
);

    logic [31:0]          mem [1 << cache_pkg::WORD_ADDR_WIDTH];
    cache_pkg::dram_rsp_t rsp_fifo [$];
    int                   due_fifo [$];
    int                   cycle;
    int                   last_due;

    initial begin
        cycle     = 0;
        last_due  = 0;
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp       = '0;
        // Contents mix every bit of the word address
        for (int a = 0; a < (1 << cache_pkg::WORD_ADDR_WIDTH); a++) begin
            mem[a] = {a[15:0], ~a[15:0]} ^ (a * 32'h9e37_79b9);
        end
    end

    always @(posedge clk) begin
        cache_pkg::dram_rsp_t fill;
        logic [15:0]          waddr;
        int                   due;
        cycle = cycle + 1;
        if (rst_n && req_valid && req_ready) begin
            fill.addr = req.addr;
            for (int b = 0; b < cache_pkg::LINE_BYTES; b++) begin
                waddr = {req.addr, 2'(b / 4)};
                if (req.op == cache_pkg::OP_WRITE && req.byteen[b]) begin
                    mem[waddr][8*(b%4) +: 8] = req.data[b/4][8*(b%4) +: 8];
                end
                fill.data[b/4][8*(b%4) +: 8] = mem[waddr][8*(b%4) +: 8];
            end
            if (req.op == cache_pkg::OP_READ) begin
                // Reads return in order
                due = cycle + 2 + int'($urandom % 5);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                rsp_fifo.push_back(fill);
                due_fifo.push_back(due);
            end
        end
    end

    // Outputs change on the falling edge
    always @(negedge clk) begin
        req_ready = ($urandom % 4) != 0;
        rsp_valid = 1'b0;
        if (due_fifo.size() != 0 && cycle >= due_fifo[0]) begin
            rsp       = rsp_fifo.pop_front();
            rsp_valid = 1'b1;
            void'(due_fifo.pop_front());
        end
    end

endmodule

`default_nettype wire

/* testbench/cache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

    localparam int NUM_RANDOM     = 400;
    // Roughly 75 cycles per random request covers misses under stalls
    localparam int TIMEOUT_CYCLES = NUM_RANDOM * 75;

    logic                 clk;
    logic                 rst_n;
    logic                 core_req_valid;
    cache_pkg::core_req_t core_req;
    logic                 core_req_ready;
    logic                 core_rsp_valid;
    cache_pkg::core_rsp_t core_rsp;
    logic                 core_rsp_ready;
    logic                 dram_req_valid;
    cache_pkg::dram_req_t dram_req;
    logic                 dram_req_ready;
    logic                 dram_rsp_valid;
    cache_pkg::dram_rsp_t dram_rsp;

    logic [31:0] shadow [1 << 16];
    logic [31:0] exp_data [256];
    logic        pending [256];
    int          num_pending = 0;
    logic [7:0]  next_tag = '0;
    int          dram_reqs = 0;
    int          cycles = 0;
    logic        rsp_stall = 1'b0;

    cache_top #(
        .NUM_BANKS      (4),
        .LINES_PER_BANK (32)
    ) u_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp)
    );

    dram_model u_dram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (dram_req_valid),
        .req       (dram_req),
        .req_ready (dram_req_ready),
        .rsp_valid (dram_rsp_valid),
        .rsp       (dram_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] init_word(input logic [15:0] addr);
        return {addr, ~addr} ^ (32'(addr) * 32'h9e37_79b9);
    endfunction

    // Expected word after merging a byte-enabled write
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  byteen);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (byteen[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic issue(input cache_pkg::req_op_e op, input logic [15:0] addr,
                         input logic [31:0] data, input logic [3:0] byteen);
        @(negedge clk);
        core_req_valid = 1'b1;
        core_req.op     = op;
        core_req.addr   = addr;
        core_req.data   = data;
        core_req.byteen = byteen;
        core_req.tag    = next_tag;
        do begin
            @(posedge clk);
        end while (!core_req_ready);
        // Accepted on this edge
        if (op == cache_pkg::OP_WRITE) begin
            shadow[addr] = merge_bytes(shadow[addr], data, byteen);
        end else begin
            exp_data[next_tag] = shadow[addr];
            pending[next_tag]  = 1'b1;
            num_pending        = num_pending + 1;
            next_tag           = next_tag + 1'b1;
        end
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (num_pending != 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
    endtask

    // Response checker
    always @(posedge clk) begin
        if (rst_n && core_rsp_valid && core_rsp_ready) begin
            assert (pending[core_rsp.tag])
            else report_failure($sformatf("[ERROR] %0t: response with unexpected tag %0d",
                                          $time, core_rsp.tag));
            assert (core_rsp.data == exp_data[core_rsp.tag])
            else report_failure($sformatf("[ERROR] %0t: tag %0d data %h, expected %h", $time,
                                          core_rsp.tag, core_rsp.data, exp_data[core_rsp.tag]));
            pending[core_rsp.tag] = 1'b0;
            num_pending = num_pending - 1;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (dram_req_valid && dram_req_ready) begin
            dram_reqs = dram_reqs + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the run did not finish in %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    always @(negedge clk) begin
        core_rsp_ready = rsp_stall ? (($urandom % 3) != 0) : 1'b1;
    end

    initial begin
        int reqs_before;
        logic [15:0] addr;
        void'($urandom(32'h8bf9_bddf));
        rst_n          = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b1;
        for (int a = 0; a < (1 << 16); a++) begin
            shadow[a] = init_word(a[15:0]);
        end
        for (int t = 0; t < 256; t++) begin
            pending[t]  = 1'b0;
            exp_data[t] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (8) begin
            @(posedge clk);
            assert (!core_rsp_valid && !dram_req_valid)
            else report_failure($sformatf("[ERROR] %0t: output valid while idle", $time));
        end

        // Repeat read must hit
        issue(cache_pkg::OP_READ, 16'h0123, '0, '0);
        wait_drained();
        reqs_before = dram_reqs;
        issue(cache_pkg::OP_READ, 16'h0123, '0, '0);
        wait_drained();
        assert (dram_reqs == reqs_before)
        else report_failure($sformatf("[ERROR] %0t: repeat read went to DRAM", $time));

        // Partial writes, hit line then miss line
        issue(cache_pkg::OP_WRITE, 16'h0123, 32'hdead_beef, 4'b0101);
        issue(cache_pkg::OP_READ, 16'h0123, '0, '0);
        issue(cache_pkg::OP_WRITE, 16'h0456, 32'hcafe_f00d, 4'b1010);
        issue(cache_pkg::OP_READ, 16'h0456, '0, '0);
        wait_drained();

        // Same bank and index, different tags
        repeat (3) begin
            issue(cache_pkg::OP_READ, 16'h0040, '0, '0);
            issue(cache_pkg::OP_READ, 16'h0240, '0, '0);
        end
        wait_drained();

        rsp_stall = 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            addr = 16'($urandom % 1024);
            if ($urandom % 2) begin
                issue(cache_pkg::OP_WRITE, addr, $urandom, 4'($urandom));
            end else begin
                issue(cache_pkg::OP_READ, addr, '0, '0);
            end
        end
        rsp_stall = 1'b0;
        wait_drained();
        // Late stray responses still reach the checker
        repeat (20) @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/cache_pkg.sv
hdl/cache_bank_sel.sv
hdl/cache_bank.sv
hdl/cache_dram_req_arb.sv
hdl/cache_core_rsp_merge.sv
hdl/cache_top.sv
testbench/dram_model.sv
testbench/cache_tb.sv
